/* tb.f */
+incdir+include
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/Cpu.sv
tb/tbCpu.sv

/* Bender.yml */
package:
  name: pipelined_cpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/hazardUnit.sv
      - hdl/executeStage.sv
      - hdl/memStage.sv
      - hdl/Cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tbCpu.sv

/* tb/tbCpu.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbCpu;
	import pipePkg::*;
	import isaPkg::*;

	localparam int MEM_WORDS   = 64;    // Data memory seen through PrAddr[5:0]
	localparam int WAIT_CYCLES = 400;
	localparam int RANDOM_RUNS = 20;

	logic    clk;
	logic    rstN;
	wordT    InstrAddr;
	wordT    Instr;
	busAddrT PrAddr;
	wordT    PrRD;
	wordT    PrWD;
	logic    PrWE;
	wordT    CurAddr;

	wordT        prog[$];
	wordT        dataMem[MEM_WORDS];
	busAddrT     expAddr[$];        // Expected stores in program order
	wordT        expData[$];
	wordT        expPc[$];
	logic [31:0] lfsrState;

	Cpu uut (
		.clk(clk), .rstN(rstN),
		.InstrAddr(InstrAddr), .Instr(Instr),
		.PrAddr(PrAddr), .PrRD(PrRD), .PrWD(PrWD), .PrWE(PrWE),
		.CurAddr(CurAddr)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// Failure reporting and checks
	//////////////////////////////////////////////////
	task automatic stopWithFailure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic abortRun(string msg);
		$display("Error at time %0t: %s", $time, msg);
		stopWithFailure();
	endtask

	task automatic checkWord(wordT got, wordT exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkAddr(busAddrT got, busAddrT exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	//////////////////////////////////////////////////
	// Encoding and random numbers
	//////////////////////////////////////////////////
	function automatic wordT rType(functT fn, int rd, int rs, int rt);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic wordT iType(logic [5:0] op, int rt, int rs, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int randBits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	// Distinct for every word of the memory
	function automatic wordT fillWord(int idx);
		return 32'hA5C3_0000 ^ (wordT'(idx) * 32'h0102_0409);
	endfunction

	function automatic wordT fetchInstr(wordT addr);
		wordT offset;
		offset = addr - `RESET_PC;
		if (addr >= `RESET_PC && offset[1:0] == 2'b00 && (offset >> 2) < prog.size())
			return prog[offset >> 2];
		return `NOP_INSTR;  // Past the end of the program
	endfunction

	//////////////////////////////////////////////////
	// Instruction-set reference
	//////////////////////////////////////////////////
	function automatic void runReference();
		wordT    regs[`REG_COUNT];
		wordT    mem[MEM_WORDS];
		wordT    instr, pc, a, b, addr, res;
		regAddrT rs, rt, rd, dst;
		aluOpT   op;
		logic    writes;
		for (int i = 0; i < `REG_COUNT; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fillWord(i);
		end
		for (int i = 0; i < prog.size(); i++) begin
			instr  = prog[i];
			pc     = `RESET_PC + 4 * i;
			rs     = instr[25:21];
			rt     = instr[20:16];
			rd     = instr[15:11];
			a      = regs[rs];
			b      = regs[rt];
			addr   = a + {{16{instr[15]}}, instr[15:0]};
			writes = 1'b0;
			dst    = rd;
			op     = ALU_ADD;
			case (instr[31:26])
				OP_SPECIAL: begin
					writes = 1'b1;
					case (instr[5:0])
						FN_ADDU: op = ALU_ADD;
						FN_SUBU: op = ALU_SUB;
						FN_OR:   op = ALU_OR;
						default: writes = 1'b0;   // Unknown funct
					endcase
				end
				OP_ORI, OP_LUI: begin
					writes = 1'b1;
					dst    = rt;
					op     = (instr[31:26] == OP_ORI) ? ALU_OR : ALU_LUI;
					b      = {16'h0000, instr[15:0]};
				end
				OP_LW: begin
					if (rt != '0)
						regs[rt] = mem[addr[7:2]];
				end
				OP_SW: begin
					mem[addr[7:2]] = b;
					expAddr.push_back(addr[31:2]);
					expData.push_back(b);
					expPc.push_back(pc);
				end
				default: ;
			endcase
			if (writes) begin
				case (op)
					ALU_SUB: res = a - b;
					ALU_OR:  res = a | b;
					ALU_LUI: res = {b[15:0], 16'h0000};
					default: res = a + b;
				endcase
				if (dst != '0)
					regs[dst] = res;
			end
		end
	endfunction

	//////////////////////////////////////////////////
	// Programs
	//////////////////////////////////////////////////
	function automatic void appendStores();
		for (int r = 1; r < 8; r++) begin
			prog.push_back(iType(OP_SW, r, 0, 16'(64 + 4 * r)));
		end
	endfunction

	function automatic void buildChain();
		prog.delete();
		prog.push_back(iType(OP_LUI, 1, 0, 16'h1234));
		prog.push_back(iType(OP_ORI, 1, 1, 16'h5678));
		prog.push_back(rType(FN_ADDU, 2, 1, 1));
		prog.push_back(rType(FN_SUBU, 3, 2, 1));  // Both bypass paths at once
		prog.push_back(rType(FN_OR, 4, 3, 2));
		prog.push_back(iType(OP_ORI, 5, 4, 16'h00ff));
		prog.push_back(rType(FN_SUBU, 6, 0, 5));  // Negative result
		prog.push_back(rType(FN_ADDU, 7, 6, 3));
		appendStores();
	endfunction

	function automatic void buildLoadUse();
		prog.delete();
		prog.push_back(iType(OP_LW, 1, 0, 16'h0000));
		prog.push_back(rType(FN_ADDU, 2, 1, 1));  // Load-use stall
		prog.push_back(iType(OP_LW, 3, 0, 16'h0004));
		prog.push_back(rType(FN_ADDU, 4, 2, 3));
		prog.push_back(iType(OP_ORI, 0, 1, 16'h7777));
		prog.push_back(rType(FN_ADDU, 0, 1, 2));
		prog.push_back(rType(FN_ADDU, 5, 0, 1));  // r0 must still read zero
		prog.push_back(iType(OP_SW, 0, 0, 16'h0008));
		prog.push_back(iType(OP_LW, 6, 0, 16'h0008));
		prog.push_back(iType(OP_SW, 6, 0, 16'h000c));
		prog.push_back(rType(FN_OR, 7, 6, 4));
		appendStores();
	endfunction

	function automatic void buildStoreAfter();
		prog.delete();
		prog.push_back(iType(OP_ORI, 1, 0, 16'hbeef));
		prog.push_back(iType(OP_SW, 1, 0, 16'h0020));
		prog.push_back(iType(OP_LUI, 2, 0, 16'hcafe));
		prog.push_back(iType(OP_SW, 2, 0, 16'h0024));
		prog.push_back(rType(FN_ADDU, 3, 1, 2));
		prog.push_back(iType(OP_SW, 3, 0, 16'h0028));
		prog.push_back(iType(OP_LW, 5, 0, 16'h0020));
		prog.push_back(iType(OP_ORI, 6, 5, 16'h0001));
		prog.push_back(iType(OP_SW, 6, 0, 16'h0030));
		appendStores();
	endfunction

	function automatic void buildRandom();
		int n, kind, rd, rs, rt;
		prog.delete();
		n = 12 + randBits(4);
		for (int i = 0; i < n; i++) begin
			kind = randBits(3);
			rd   = randBits(3);
			rs   = randBits(3);
			rt   = randBits(3);
			case (kind)
				0: prog.push_back(rType(FN_ADDU, rd, rs, rt));
				1: prog.push_back(rType(FN_SUBU, rd, rs, rt));
				2: prog.push_back(rType(FN_OR, rd, rs, rt));
				3: prog.push_back(iType(OP_ORI, rt, rs, 16'(randBits(16))));
				4: prog.push_back(iType(OP_LUI, rt, 0, 16'(randBits(16))));
				5: prog.push_back(iType(OP_LW, rt, 0, 16'(4 * randBits(4))));
				6: prog.push_back(iType(OP_SW, rt, 0, 16'(4 * randBits(4))));
				default: prog.push_back(iType(6'h0c, rt, rs, 16'(randBits(16))));   // andi is not kept
			endcase
		end
		appendStores();
	endfunction

	//////////////////////////////////////////////////
	// Bus models and store compare
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		#1;
		Instr = fetchInstr(InstrAddr);
		PrRD  = dataMem[PrAddr[5:0]];
	end

	always @(negedge clk) begin
		if (rstN && PrWE === 1'b1)
			dataMem[PrAddr[5:0]] = PrWD;
	end

	always @(negedge clk) begin
		if (!rstN) begin
			if (PrWE !== 1'b0)
				abortRun("PrWE was not low during reset");
		end else if (PrWE === 1'b1) begin
			if (expAddr.size() == 0) begin
				abortRun("A store appeared that the program does not contain");
			end else begin
				checkAddr(PrAddr, expAddr.pop_front(), "PrAddr");
				checkWord(PrWD, expData.pop_front(), "PrWD");
				checkWord(CurAddr, expPc.pop_front(), "CurAddr");
			end
		end else if (PrWE !== 1'b0) begin
			abortRun("PrWE was unknown after reset");
		end
	end

	task automatic runProgram(string name);
		int cycles;
		expAddr.delete();
		expData.delete();
		expPc.delete();
		runReference();
		@(posedge clk);
		#1;
		rstN = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			dataMem[i] = fillWord(i);
		end
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkWord(InstrAddr, `RESET_PC, "InstrAddr after reset");
		cycles = 0;
		while (expAddr.size() != 0 && cycles < WAIT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (expAddr.size() != 0)
			abortRun($sformatf("%s stopped storing with %0d stores left", name, expAddr.size()));
		repeat (8) @(negedge clk);  // Window for stray stores
		$display("%s: %0d instructions ok", name, prog.size());
	endtask

	initial begin
		clk       = 1'b0;
		rstN      = 1'b0;
		Instr     = `NOP_INSTR;
		PrRD      = '0;
		lfsrState = 32'h88b5_4eb9;
		buildChain();
		runProgram("dependent ALU chain");
		buildLoadUse();
		runProgram("load-use and r0");
		buildStoreAfter();
		runProgram("store after producer");
		for (int i = 0; i < RANDOM_RUNS; i++) begin
			buildRandom();
			runProgram($sformatf("random program %0d", i));
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* hdl/Cpu.sv */
`timescale 1ns/1ps

module Cpu (
	input  logic             clk,
	input  logic             rstN,
	output pipePkg::wordT    InstrAddr,
	input  pipePkg::wordT    Instr,
	output pipePkg::busAddrT PrAddr,
	input  pipePkg::wordT    PrRD,
	output pipePkg::wordT    PrWD,
	output logic             PrWE,
	output pipePkg::wordT    CurAddr
);
	import pipePkg::*;
	import isaPkg::*;

	logic      Stall;
	wordT      InstrIfId, PcIfId;
	regAddrT   RAddr0Id, RAddr1Id;
	stageTimeT Tuse0Id, Tuse1Id;
	regAddrT   RAddr0Ex, RAddr1Ex, WAddrEx;
	wordT      Data0Ex, Data1Ex, ImmEx, PcEx;
	aluOpT     AluOpEx;
	logic      UseImmEx, LoadEx, StoreEx;
	stageTimeT Tuse0Ex, Tuse1Ex, TnewEx;
	bypassSelT Bypass0Sel, Bypass1Sel;
	wordT      AluOutMem, StoreDataMem;
	regAddrT   WAddrMem;
	stageTimeT TnewMem;
	logic      LoadMem, StoreMem;
	wordT      WbData;
	regAddrT   WAddrWb;

	////////////////////// Hazards /////////////////////
	hazardUnit hazardUnit (
		.RAddr0Id(RAddr0Id), .RAddr1Id(RAddr1Id),
		.Tuse0Id(Tuse0Id), .Tuse1Id(Tuse1Id),
		.RAddr0Ex(RAddr0Ex), .RAddr1Ex(RAddr1Ex),
		.WAddrEx(WAddrEx), .TnewEx(TnewEx),
		.WAddrMem(WAddrMem), .TnewMem(TnewMem),
		.WAddrWb(WAddrWb),
		.Bypass0Sel(Bypass0Sel), .Bypass1Sel(Bypass1Sel),
		.Stall(Stall)
	);

	///////////////////////// IF ///////////////////////
	fetchStage fetchStage (
		.clk(clk), .rstN(rstN),
		.Stall(Stall),
		.InstrAddr(InstrAddr), .Instr(Instr),
		.InstrIfId(InstrIfId), .PcIfId(PcIfId)
	);

	///////////////////////// ID ///////////////////////
	decodeStage decodeStage (
		.clk(clk), .rstN(rstN),
		.Stall(Stall),
		.InstrIfId(InstrIfId), .PcIfId(PcIfId),
		.WAddrWb(WAddrWb), .WbData(WbData),     // Register write
		.RAddr0Id(RAddr0Id), .RAddr1Id(RAddr1Id),
		.Tuse0Id(Tuse0Id), .Tuse1Id(Tuse1Id),
		.RAddr0Ex(RAddr0Ex), .RAddr1Ex(RAddr1Ex), .WAddrEx(WAddrEx),
		.Data0Ex(Data0Ex), .Data1Ex(Data1Ex), .ImmEx(ImmEx),
		.AluOpEx(AluOpEx), .UseImmEx(UseImmEx),
		.LoadEx(LoadEx), .StoreEx(StoreEx),
		.PcEx(PcEx),
		.Tuse0Ex(Tuse0Ex), .Tuse1Ex(Tuse1Ex), .TnewEx(TnewEx)
	);

	///////////////////////// EX ///////////////////////
	executeStage executeStage (
		.clk(clk), .rstN(rstN),
		.WAddrEx(WAddrEx),
		.Data0Ex(Data0Ex), .Data1Ex(Data1Ex), .ImmEx(ImmEx),
		.AluOpEx(AluOpEx), .UseImmEx(UseImmEx),
		.LoadEx(LoadEx), .StoreEx(StoreEx),
		.PcEx(PcEx),
		.Tuse0Ex(Tuse0Ex), .Tuse1Ex(Tuse1Ex), .TnewEx(TnewEx),
		.Bypass0Sel(Bypass0Sel), .Bypass1Sel(Bypass1Sel),
		.WbData(WbData),    // MEM/WB bypass
		.AluOutMem(AluOutMem), .StoreDataMem(StoreDataMem),
		.WAddrMem(WAddrMem), .TnewMem(TnewMem),
		.LoadMem(LoadMem), .StoreMem(StoreMem),
		.PcMem(CurAddr)     // PC of the instruction in MEM
	);

	///////////////////////// MEM //////////////////////
	memStage memStage (
		.clk(clk), .rstN(rstN),
		.AluOutMem(AluOutMem), .StoreDataMem(StoreDataMem),
		.WAddrMem(WAddrMem),
		.LoadMem(LoadMem), .StoreMem(StoreMem),
		.PrAddr(PrAddr), .PrRD(PrRD), .PrWD(PrWD), .PrWE(PrWE),
		.WbData(WbData), .WAddrWb(WAddrWb)
	);

endmodule

/* hdl/memStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memStage (
	input  logic             clk,
	input  logic             rstN,
	input  pipePkg::wordT    AluOutMem,
	input  pipePkg::wordT    StoreDataMem,
	input  pipePkg::regAddrT WAddrMem,
	input  logic             LoadMem,
	input  logic             StoreMem,
	output pipePkg::busAddrT PrAddr,
	input  pipePkg::wordT    PrRD,
	output pipePkg::wordT    PrWD,
	output logic             PrWE,
	output pipePkg::wordT    WbData,
	output pipePkg::regAddrT WAddrWb
);
	import pipePkg::*;

	wordT wbNext;

	//////////////////////////////////////////////////
	// Processor bus
	//////////////////////////////////////////////////
	assign PrAddr = AluOutMem[`WORD_W-1:`WORD_W-`BUS_ADDR_W];  // Word address
	assign PrWD   = StoreDataMem;
	assign PrWE   = StoreMem;   // One cycle per store

	// Load data sampled in the same cycle
	assign wbNext = LoadMem ? PrRD : AluOutMem;

	//////////////////////////////////////////////////
	// MEM/WB register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			WAddrWb <= '0;  // No write-back after reset
		end else begin
			WAddrWb <= WAddrMem;
		end
	end

	always_ff @(posedge clk) begin
		WbData <= wbNext;
	end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeStage (
	input  logic               clk,
	input  logic               rstN,
	input  pipePkg::regAddrT   WAddrEx,
	input  pipePkg::wordT      Data0Ex,
	input  pipePkg::wordT      Data1Ex,
	input  pipePkg::wordT      ImmEx,
	input  isaPkg::aluOpT      AluOpEx,
	input  logic               UseImmEx,
	input  logic               LoadEx,
	input  logic               StoreEx,
	input  pipePkg::wordT      PcEx,
	input  pipePkg::stageTimeT Tuse0Ex,
	input  pipePkg::stageTimeT Tuse1Ex,
	input  pipePkg::stageTimeT TnewEx,
	input  pipePkg::bypassSelT Bypass0Sel,
	input  pipePkg::bypassSelT Bypass1Sel,
	input  pipePkg::wordT      WbData,
	output pipePkg::wordT      AluOutMem,
	output pipePkg::wordT      StoreDataMem,
	output pipePkg::regAddrT   WAddrMem,
	output pipePkg::stageTimeT TnewMem,
	output logic               LoadMem,
	output logic               StoreMem,
	output pipePkg::wordT      PcMem
);
	import pipePkg::*;
	import isaPkg::*;

	wordT opA, opB, aluB, aluOut;

	function automatic wordT bypassMux(bypassSelT sel, wordT regVal, wordT exMem, wordT memWb);
		case (sel)
			BYP_EXMEM: return exMem;
			BYP_MEMWB: return memWb;
			default:   return regVal;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Operands and ALU
	//////////////////////////////////////////////////
	always_comb begin
		// Unread operands forced to zero
		opA = (Tuse0Ex == `TUSE_NONE) ? '0 : bypassMux(Bypass0Sel, Data0Ex, AluOutMem, WbData);
		opB = (Tuse1Ex == `TUSE_NONE) ? '0 : bypassMux(Bypass1Sel, Data1Ex, AluOutMem, WbData);
		aluB = UseImmEx ? ImmEx : opB;
	end

	always_comb begin
		case (AluOpEx)
			ALU_SUB: aluOut = opA - aluB;
			ALU_OR:  aluOut = opA | aluB;
			ALU_LUI: aluOut = {aluB[15:0], 16'h0000};
			default: aluOut = opA + aluB;   // Also the load/store address
		endcase
	end

	//////////////////////////////////////////////////
	// EX/MEM register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			WAddrMem <= '0;
			TnewMem  <= `TNEW_NONE;
			LoadMem  <= 1'b0;
			StoreMem <= 1'b0;
		end else begin
			WAddrMem <= WAddrEx;
			TnewMem  <= (TnewEx == `TNEW_NONE) ? `TNEW_NONE : TnewEx - 2'd1;   // One stage closer
			LoadMem  <= LoadEx;
			StoreMem <= StoreEx;
		end
	end

	always_ff @(posedge clk) begin
		AluOutMem    <= aluOut;
		StoreDataMem <= opB;
		PcMem        <= PcEx;
	end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input  pipePkg::regAddrT   RAddr0Id,
	input  pipePkg::regAddrT   RAddr1Id,
	input  pipePkg::stageTimeT Tuse0Id,
	input  pipePkg::stageTimeT Tuse1Id,
	input  pipePkg::regAddrT   RAddr0Ex,
	input  pipePkg::regAddrT   RAddr1Ex,
	input  pipePkg::regAddrT   WAddrEx,
	input  pipePkg::stageTimeT TnewEx,
	input  pipePkg::regAddrT   WAddrMem,
	input  pipePkg::stageTimeT TnewMem,
	input  pipePkg::regAddrT   WAddrWb,
	output pipePkg::bypassSelT Bypass0Sel,
	output pipePkg::bypassSelT Bypass1Sel,
	output logic               Stall
);
	import pipePkg::*;

	// Newest ready producer wins
	function automatic bypassSelT pickSource(
		regAddrT   rAddr,
		regAddrT   wAddrMem,
		stageTimeT tnewMem,
		regAddrT   wAddrWb
	);
		if (rAddr == '0)
			return BYP_REG;
		if (rAddr == wAddrMem && tnewMem == '0)
			return BYP_EXMEM;
		if (rAddr == wAddrWb)
			return BYP_MEMWB;
		return BYP_REG;
	endfunction

	// Producer in EX not ready in time for this reader
	function automatic logic tooEarly(
		regAddrT   rAddr,
		stageTimeT tUse,
		regAddrT   wAddr,
		stageTimeT tNew
	);
		return (rAddr != '0) && (rAddr == wAddr) && (tUse < tNew);
	endfunction

	assign Bypass0Sel = pickSource(RAddr0Ex, WAddrMem, TnewMem, WAddrWb);
	assign Bypass1Sel = pickSource(RAddr1Ex, WAddrMem, TnewMem, WAddrWb);

	// Only a load in EX can trip this
	assign Stall = tooEarly(RAddr0Id, Tuse0Id, WAddrEx, TnewEx)
		|| tooEarly(RAddr1Id, Tuse1Id, WAddrEx, TnewEx);

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decodeStage (
	input  logic               clk,
	input  logic               rstN,
	input  logic               Stall,
	input  pipePkg::wordT      InstrIfId,
	input  pipePkg::wordT      PcIfId,
	input  pipePkg::regAddrT   WAddrWb,
	input  pipePkg::wordT      WbData,
	output pipePkg::regAddrT   RAddr0Id,
	output pipePkg::regAddrT   RAddr1Id,
	output pipePkg::stageTimeT Tuse0Id,
	output pipePkg::stageTimeT Tuse1Id,
	output pipePkg::regAddrT   RAddr0Ex,
	output pipePkg::regAddrT   RAddr1Ex,
	output pipePkg::regAddrT   WAddrEx,
	output pipePkg::wordT      Data0Ex,
	output pipePkg::wordT      Data1Ex,
	output pipePkg::wordT      ImmEx,
	output isaPkg::aluOpT      AluOpEx,
	output logic               UseImmEx,
	output logic               LoadEx,
	output logic               StoreEx,
	output pipePkg::wordT      PcEx,
	output pipePkg::stageTimeT Tuse0Ex,
	output pipePkg::stageTimeT Tuse1Ex,
	output pipePkg::stageTimeT TnewEx
);
	import pipePkg::*;
	import isaPkg::*;

	opcodeT    opcode;
	functT     funct;
	regAddrT   rs, rt, rd;
	immT       imm;
	regAddrT   wAddr;
	wordT      immExt;
	aluOpT     aluOp;
	logic      useImm, isLoad, isStore;
	stageTimeT tnew;
	wordT      regFile [`REG_COUNT];
	wordT      rData0, rData1;
	logic      wbEn;

	// Instruction fields
	assign opcode = opcodeT'(InstrIfId[`WORD_W-1 -: OPCODE_W]);
	assign funct  = functT'(InstrIfId[FUNCT_W-1:0]);
	assign rs     = InstrIfId[25:21];
	assign rt     = InstrIfId[20:16];
	assign rd     = InstrIfId[15:11];
	assign imm    = InstrIfId[IMM_W-1:0];

	assign RAddr0Id = rs;
	assign RAddr1Id = rt;

	//////////////////////////////////////////////////
	// Decoder
	//////////////////////////////////////////////////
	always_comb begin
		wAddr   = '0;           // Unknown encodings fall through as no-ops
		aluOp   = ALU_ADD;
		useImm  = 1'b0;
		isLoad  = 1'b0;
		isStore = 1'b0;
		Tuse0Id = `TUSE_NONE;
		Tuse1Id = `TUSE_NONE;
		tnew    = `TNEW_NONE;
		immExt  = {{(`WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
		case (opcode)
			OP_SPECIAL: begin
				if (funct inside {FN_ADDU, FN_SUBU, FN_OR}) begin
					wAddr   = rd;
					Tuse0Id = `TUSE_EX;
					Tuse1Id = `TUSE_EX;
					tnew    = `TNEW_ALU;
				end
				case (funct)
					FN_SUBU: aluOp = ALU_SUB;
					FN_OR:   aluOp = ALU_OR;
					default: aluOp = ALU_ADD;
				endcase
			end
			OP_ORI, OP_LUI: begin
				wAddr   = rt;
				aluOp   = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
				useImm  = 1'b1;
				immExt  = {{(`WORD_W-IMM_W){1'b0}}, imm};   // Zero extended
				Tuse0Id = (opcode == OP_ORI) ? `TUSE_EX : `TUSE_NONE;
				tnew    = `TNEW_ALU;
			end
			OP_LW: begin
				wAddr   = rt;
				useImm  = 1'b1;
				isLoad  = 1'b1;
				Tuse0Id = `TUSE_EX;
				tnew    = `TNEW_LOAD;
			end
			OP_SW: begin
				useImm  = 1'b1;
				isStore = 1'b1;
				Tuse0Id = `TUSE_EX;
				Tuse1Id = `TUSE_EX;     // Store data is bypassed in EX
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////
	assign wbEn = (WAddrWb != '0);  // Register 0 stays zero

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbEn) begin
			regFile[WAddrWb] <= WbData;
		end
	end

	// Write-through from WB
	always_comb begin
		rData0 = (wbEn && rs == WAddrWb) ? WbData : regFile[rs];
		rData1 = (wbEn && rt == WAddrWb) ? WbData : regFile[rt];
	end

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN || Stall) begin   // Bubble
			RAddr0Ex <= '0;
			RAddr1Ex <= '0;
			WAddrEx  <= '0;
			AluOpEx  <= ALU_ADD;
			UseImmEx <= 1'b0;
			LoadEx   <= 1'b0;
			StoreEx  <= 1'b0;
			Tuse0Ex  <= `TUSE_NONE;
			Tuse1Ex  <= `TUSE_NONE;
			TnewEx   <= `TNEW_NONE;
		end else begin
			RAddr0Ex <= rs;
			RAddr1Ex <= rt;
			WAddrEx  <= wAddr;
			AluOpEx  <= aluOp;
			UseImmEx <= useImm;
			LoadEx   <= isLoad;
			StoreEx  <= isStore;
			Tuse0Ex  <= Tuse0Id;
			Tuse1Ex  <= Tuse1Id;
			TnewEx   <= tnew;
		end
	end

	always_ff @(posedge clk) begin
		Data0Ex <= rData0;
		Data1Ex <= rData1;
		ImmEx   <= immExt;
		PcEx    <= PcIfId;
	end

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchStage (
	input  logic          clk,
	input  logic          rstN,
	input  logic          Stall,
	output pipePkg::wordT InstrAddr,
	input  pipePkg::wordT Instr,
	output pipePkg::wordT InstrIfId,
	output pipePkg::wordT PcIfId
);
	import pipePkg::*;

	wordT pc;

	assign InstrAddr = pc;  // Instruction port answers in the same cycle

	// Program counter
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (!Stall) begin
			pc <= pc + 32'd4;
		end
	end

	//////////////////////////////////////////////////
	// IF/ID register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			InstrIfId <= `NOP_INSTR;
		end else if (!Stall) begin
			InstrIfId <= Instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!Stall) begin
			PcIfId <= pc;   // Held with the instruction
		end
	end

endmodule

/* hdl/pipePkg.sv */
`include "cpu_defines.svh"

package pipePkg;

	// Data word and processor bus address
	typedef logic [`WORD_W-1:0]     wordT;
	typedef logic [`BUS_ADDR_W-1:0] busAddrT;

	// General register number
	typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

	// Tuse/Tnew count
	typedef logic [1:0] stageTimeT;

	// Source of an EX operand
	typedef enum logic [1:0] {
		BYP_REG,                // Value read in ID
		BYP_EXMEM,              // ALU result one ahead
		BYP_MEMWB               // Write-back value two ahead
	} bypassSelT;

endpackage

/* hdl/isaPkg.sv */
package isaPkg;

	// Instruction field widths
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;
	localparam int IMM_W    = 16;

	typedef logic [IMM_W-1:0] immT;

	// Primary opcodes that the core executes
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,     // R-type selected by funct
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcodeT;

	// R-type funct codes
	typedef enum logic [FUNCT_W-1:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_OR   = 6'h25
	} functT;

	// ALU operation
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_LUI                 // Immediate into the upper half
	} aluOpT;

endpackage

/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Core constants
`define RESET_PC   32'h0000_3000
`define REG_COUNT  32
`define WORD_W     32
`define BUS_ADDR_W 30           // PrAddr carries word addresses
`define NOP_INSTR  32'h0000_0000

// Tuse and Tnew encodings, counted in stages
`define TUSE_EX    2'd1         // Operand needed at EX
`define TUSE_NONE  2'd3         // Operand not read
`define TNEW_NONE  2'd0
`define TNEW_ALU   2'd1
`define TNEW_LOAD  2'd2

`endif
